// ==== Makefile ====
# Verilator flow for the execute stage

VERILATOR ?= verilator
TOP       ?= exec_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= Test OK

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST) | grep -v '^+') verif/exec_tests.svh
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	@out=$$(./$(SIM_BIN)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== alu/exec_alu.sv ====
`timescale 1ns/1ps

module exec_alu (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              valid_in,
    input  exec_pkg::uop_t    uop,
    input  exec_pkg::cond_t   cond,
    input  exec_pkg::size_t   size,
    input  exec_pkg::data_t   op1,
    input  exec_pkg::data_t   op2,
    input  exec_pkg::addr_t   eip,
    input  logic              pred_taken,
    input  exec_pkg::addr_t   pred_target,
    input  exec_pkg::data_t   esp_in,
    input  exec_pkg::data_t   esi_in,
    input  exec_pkg::data_t   edi_in,
    output logic              a_valid,
    output exec_pkg::uop_t    a_uop,
    output exec_pkg::cond_t   a_cond,
    output exec_pkg::size_t   a_size,
    output exec_pkg::data_t   a_result,
    output exec_pkg::flags_t  a_cand_flags,
    output exec_pkg::addr_t   a_eip,
    output logic              a_pred_taken,
    output exec_pkg::addr_t   a_pred_target,
    output exec_pkg::data_t   a_esp,
    output exec_pkg::data_t   a_esi,
    output exec_pkg::data_t   a_edi
);

    exec_pkg::data_t  size_mask;
    exec_pkg::data_t  op1_m;
    exec_pkg::data_t  op2_m;
    exec_pkg::data_t  op1_sx;
    exec_pkg::data_t  res;
    exec_pkg::data_t  res_out;
    exec_pkg::flags_t cand;
    int               msb;        // Top bit of the operand size
    logic [4:0]       amt;
    logic [32:0]      sum;
    logic [63:0]      shl_wide;
    logic [63:0]      sar_wide;
    logic             cf;
    logic             of;

    always_comb begin
        case (size)
            exec_pkg::SIZE_B: begin
                size_mask = 32'h0000_00ff;
                msb       = 7;
                op1_sx    = {{24{op1[7]}}, op1[7:0]};
            end
            exec_pkg::SIZE_W: begin
                size_mask = 32'h0000_ffff;
                msb       = 15;
                op1_sx    = {{16{op1[15]}}, op1[15:0]};
            end
            default: begin
                size_mask = 32'hffff_ffff;
                msb       = 31;
                op1_sx    = op1;
            end
        endcase

        op1_m    = op1 & size_mask;
        op2_m    = op2 & size_mask;
        amt      = op2[4:0];
        sum      = {1'b0, op1_m} + {1'b0, op2_m};
        shl_wide = {32'd0, op1_m} << amt;                // Bits pushed past msb are the carry
        sar_wide = $signed({op1_sx, 32'd0}) >>> amt;     // Low half catches shifted-out bits

        res = '0;
        cf  = 1'b0;
        of  = 1'b0;
        case (uop)
            exec_pkg::OP_ADD: begin
                res = sum[31:0];
                cf  = sum[msb+1];
                of  = (op1_m[msb] == op2_m[msb]) && (sum[msb] != op1_m[msb]);
            end
            exec_pkg::OP_AND:   res = op1 & op2;     // CF and OF stay zero
            exec_pkg::OP_OR:    res = op1 | op2;
            exec_pkg::OP_NOT:   res = ~op1;
            exec_pkg::OP_SAL: begin
                res = shl_wide[31:0];
                cf  = (amt != 5'd0) && shl_wide[msb+1];
                of  = shl_wide[msb] ^ cf;             // Sign changed by the shift
            end
            exec_pkg::OP_SAR: begin
                res = sar_wide[63:32];
                cf  = (amt != 5'd0) && sar_wide[31];
            end
            exec_pkg::OP_MOV, exec_pkg::OP_CMOVC: res = op2;
            exec_pkg::OP_JMP, exec_pkg::OP_JCC:   res = eip + op2;   // Branch target
            exec_pkg::OP_PUSH:  res = op1;
            exec_pkg::OP_POP:   res = op2;
            default:            res = '0;
        endcase

        // Branch targets are full addresses, everything else is trimmed to size
        if (uop == exec_pkg::OP_JMP || uop == exec_pkg::OP_JCC)
            res_out = res;
        else
            res_out = res & size_mask;

        cand                   = '0;   // DF is owned by the flags register
        cand[exec_pkg::FLAG_CF] = cf;
        cand[exec_pkg::FLAG_ZF] = ((res & size_mask) == '0);
        cand[exec_pkg::FLAG_SF] = res[msb];
        cand[exec_pkg::FLAG_OF] = of;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            a_valid <= 1'b0;
        else
            a_valid <= valid_in;
    end

    always_ff @(posedge clk) begin
        if (valid_in) begin
            a_uop         <= uop;
            a_cond        <= cond;
            a_size        <= size;
            a_result      <= res_out;
            a_cand_flags  <= cand;
            a_eip         <= eip;
            a_pred_taken  <= pred_taken;
            a_pred_target <= pred_target;
            a_esp         <= esp_in;
            a_esi         <= esi_in;
            a_edi         <= edi_in;
        end
    end

endmodule

// ==== alu/exec_flags.sv ====
`timescale 1ns/1ps

module exec_flags (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              a_valid,
    input  exec_pkg::uop_t    a_uop,
    input  exec_pkg::flags_t  a_cand_flags,
    output exec_pkg::flags_t  cur_flags
);

    exec_pkg::flags_t mask;
    exec_pkg::flags_t next_flags;

    always_comb begin
        mask = exec_pkg::flag_mask(a_uop);

        // Masked bits come from the candidate, the rest hold
        next_flags = (cur_flags & ~mask) | (a_cand_flags & mask);

        // Direction flag instructions
        if (a_uop == exec_pkg::OP_CLD)
            next_flags[exec_pkg::FLAG_DF] = 1'b0;
        else if (a_uop == exec_pkg::OP_STD)
            next_flags[exec_pkg::FLAG_DF] = 1'b1;
    end

    // Commits at the edge that closes stage B
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            cur_flags <= '0;
        else if (a_valid)
            cur_flags <= next_flags;
    end

endmodule

// ==== common/exec_pkg.sv ====
package exec_pkg;

    localparam int DATA_W  = 32;
    localparam int ADDR_W  = 32;
    localparam int FLAGS_W = 5;

    typedef logic [DATA_W-1:0]  data_t;   // Operand or result word
    typedef logic [ADDR_W-1:0]  addr_t;   // Fetch or branch target address
    typedef logic [1:0]         size_t;   // Operand size code
    typedef logic [FLAGS_W-1:0] flags_t;  // CF ZF SF OF DF

    // Bit positions inside flags_t
    localparam int FLAG_CF = 0;
    localparam int FLAG_ZF = 1;
    localparam int FLAG_SF = 2;
    localparam int FLAG_OF = 3;
    localparam int FLAG_DF = 4;

    localparam size_t SIZE_B = 2'd0;  // 1 byte
    localparam size_t SIZE_W = 2'd1;  // 2 bytes
    localparam size_t SIZE_D = 2'd2;  // 4 bytes

    typedef enum logic [3:0] {
        OP_ADD, OP_AND, OP_OR, OP_NOT,
        OP_SAL, OP_SAR, OP_MOV, OP_CMOVC,
        OP_JMP, OP_JCC, OP_PUSH, OP_POP,
        OP_MOVS, OP_CLD, OP_STD
    } uop_t;

    typedef enum logic [1:0] {
        CC_ALWAYS, CC_C, CC_Z, CC_NZ
    } cond_t;

    // Flags each op is allowed to write
    function automatic flags_t flag_mask(uop_t op);
        flags_t m;
        m = '0;
        case (op)
            OP_ADD, OP_AND, OP_OR, OP_SAL, OP_SAR: begin
                m[FLAG_CF] = 1'b1;
                m[FLAG_ZF] = 1'b1;
                m[FLAG_SF] = 1'b1;
                m[FLAG_OF] = 1'b1;
            end
            OP_CLD, OP_STD: m[FLAG_DF] = 1'b1;
            default: m = '0;
        endcase
        return m;
    endfunction

endpackage

// ==== sources.f ====
+incdir+verif
common/exec_pkg.sv
alu/exec_alu.sv
alu/exec_flags.sv
src/cond_resolve.sv
src/ptr_update.sv
src/exec_top.sv
verif/exec_tb.sv

// ==== src/cond_resolve.sv ====
`timescale 1ns/1ps

module cond_resolve (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              a_valid,
    input  exec_pkg::uop_t    a_uop,
    input  exec_pkg::cond_t   a_cond,
    input  exec_pkg::data_t   a_result,
    input  exec_pkg::addr_t   a_eip,
    input  logic              a_pred_taken,
    input  exec_pkg::addr_t   a_pred_target,
    input  exec_pkg::flags_t  cur_flags,
    output logic              out_valid,
    output exec_pkg::data_t   result,
    output logic              br_valid,
    output logic              br_taken,
    output logic              br_correct,
    output exec_pkg::addr_t   br_target
);

    logic cf;
    logic zf;
    logic cond_true;
    logic is_br;
    logic taken;
    logic skip;
    logic match;

    always_comb begin
        cf = cur_flags[exec_pkg::FLAG_CF];
        zf = cur_flags[exec_pkg::FLAG_ZF];
        case (a_cond)
            exec_pkg::CC_C:  cond_true = cf;
            exec_pkg::CC_Z:  cond_true = zf;
            exec_pkg::CC_NZ: cond_true = !zf;
            default:         cond_true = 1'b1;
        endcase

        is_br = (a_uop == exec_pkg::OP_JMP) || (a_uop == exec_pkg::OP_JCC);
        taken = (a_uop == exec_pkg::OP_JMP) || cond_true;    // JMP ignores the code
        skip  = (a_uop == exec_pkg::OP_CMOVC) && !cf;        // Move without carry drops out

        // Direction must agree, target only matters when taken
        match = (taken == a_pred_taken) && (!taken || (a_pred_target == a_result));
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            br_valid   <= 1'b0;
            br_taken   <= 1'b0;
            br_correct <= 1'b0;
        end else begin
            out_valid  <= a_valid && !skip;
            br_valid   <= a_valid && is_br;
            br_taken   <= a_valid && is_br && taken;
            br_correct <= a_valid && is_br && match;
        end
    end

    always_ff @(posedge clk) begin
        result    <= a_result;
        br_target <= taken ? a_result : a_eip + 32'd1;   // Fall through to next fetch
    end

endmodule

// ==== src/exec_top.sv ====
`timescale 1ns/1ps

module exec_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              valid_in,
    input  exec_pkg::uop_t    uop,
    input  exec_pkg::cond_t   cond,
    input  exec_pkg::size_t   size,
    input  exec_pkg::data_t   op1,
    input  exec_pkg::data_t   op2,
    input  exec_pkg::addr_t   eip,
    input  logic              pred_taken,
    input  exec_pkg::addr_t   pred_target,
    input  exec_pkg::data_t   esp_in,
    input  exec_pkg::data_t   esi_in,
    input  exec_pkg::data_t   edi_in,
    output logic              out_valid,
    output exec_pkg::data_t   result,
    output exec_pkg::flags_t  flags,
    output logic              br_valid,
    output logic              br_taken,
    output logic              br_correct,
    output exec_pkg::addr_t   br_target,
    output exec_pkg::data_t   esp_out,
    output exec_pkg::data_t   esi_out,
    output exec_pkg::data_t   edi_out
);

    // Stage A registers
    logic             a_valid;
    exec_pkg::uop_t   a_uop;
    exec_pkg::cond_t  a_cond;
    exec_pkg::size_t  a_size;
    exec_pkg::data_t  a_result;
    exec_pkg::flags_t a_cand_flags;
    exec_pkg::addr_t  a_eip;
    logic             a_pred_taken;
    exec_pkg::addr_t  a_pred_target;
    exec_pkg::data_t  a_esp;
    exec_pkg::data_t  a_esi;
    exec_pkg::data_t  a_edi;

    exec_pkg::flags_t cur_flags;  // Flags of all older ops

    exec_alu u_alu (
        .clk(clk), .rst_n(rst_n), .valid_in(valid_in),
        .uop(uop), .cond(cond), .size(size), .op1(op1), .op2(op2),
        .eip(eip), .pred_taken(pred_taken), .pred_target(pred_target),
        .esp_in(esp_in), .esi_in(esi_in), .edi_in(edi_in),
        .a_valid(a_valid), .a_uop(a_uop), .a_cond(a_cond), .a_size(a_size),
        .a_result(a_result), .a_cand_flags(a_cand_flags), .a_eip(a_eip),
        .a_pred_taken(a_pred_taken), .a_pred_target(a_pred_target),
        .a_esp(a_esp), .a_esi(a_esi), .a_edi(a_edi)
    );

    exec_flags u_flags (
        .clk(clk), .rst_n(rst_n), .a_valid(a_valid), .a_uop(a_uop),
        .a_cand_flags(a_cand_flags), .cur_flags(cur_flags)
    );

    cond_resolve u_cond (
        .clk(clk), .rst_n(rst_n), .a_valid(a_valid), .a_uop(a_uop),
        .a_cond(a_cond), .a_result(a_result), .a_eip(a_eip),
        .a_pred_taken(a_pred_taken), .a_pred_target(a_pred_target),
        .cur_flags(cur_flags), .out_valid(out_valid), .result(result),
        .br_valid(br_valid), .br_taken(br_taken), .br_correct(br_correct),
        .br_target(br_target)
    );

    ptr_update u_ptr (
        .clk(clk), .rst_n(rst_n), .a_valid(a_valid), .a_uop(a_uop),
        .a_size(a_size), .a_esp(a_esp), .a_esi(a_esi), .a_edi(a_edi),
        .cur_flags(cur_flags), .esp_out(esp_out), .esi_out(esi_out),
        .edi_out(edi_out)
    );

    assign flags = cur_flags;     // Already includes the op leaving stage B

endmodule

// ==== src/ptr_update.sv ====
`timescale 1ns/1ps

module ptr_update (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              a_valid,
    input  exec_pkg::uop_t    a_uop,
    input  exec_pkg::size_t   a_size,
    input  exec_pkg::data_t   a_esp,
    input  exec_pkg::data_t   a_esi,
    input  exec_pkg::data_t   a_edi,
    input  exec_pkg::flags_t  cur_flags,
    output exec_pkg::data_t   esp_out,
    output exec_pkg::data_t   esi_out,
    output exec_pkg::data_t   edi_out
);

    exec_pkg::data_t step;
    exec_pkg::data_t esp_nxt;
    exec_pkg::data_t esi_nxt;
    exec_pkg::data_t edi_nxt;
    logic            df;

    always_comb begin
        case (a_size)
            exec_pkg::SIZE_B: step = 32'd1;
            exec_pkg::SIZE_W: step = 32'd2;
            default:          step = 32'd4;
        endcase

        df      = cur_flags[exec_pkg::FLAG_DF];
        esp_nxt = a_esp;
        esi_nxt = a_esi;
        edi_nxt = a_edi;
        case (a_uop)
            exec_pkg::OP_PUSH: esp_nxt = a_esp - step;   // Stack grows down
            exec_pkg::OP_POP:  esp_nxt = a_esp + step;
            exec_pkg::OP_MOVS: begin
                // DF set walks the strings backward
                esi_nxt = df ? a_esi - step : a_esi + step;
                edi_nxt = df ? a_edi - step : a_edi + step;
            end
            default: begin
                esp_nxt = a_esp;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            esp_out <= '0;
            esi_out <= '0;
            edi_out <= '0;
        end else if (a_valid) begin
            esp_out <= esp_nxt;
            esi_out <= esi_nxt;
            edi_out <= edi_nxt;
        end
    end

endmodule

// ==== verif/exec_tests.svh ====
task automatic test_reset();
    cur_test = "reset";
    @(negedge clk);
    check_val("out_valid", 32'd0, 32'(out_valid));
    check_val("br_valid", 32'd0, 32'(br_valid));
    check_val("br_taken", 32'd0, 32'(br_taken));
    check_val("br_correct", 32'd0, 32'(br_correct));
    check_val("flags", 32'd0, 32'(flags));
    check_val("esp_out", 32'd0, esp_out);
    check_val("esi_out", 32'd0, esi_out);
    check_val("edi_out", 32'd0, edi_out);
endtask

task automatic test_alu();
    exec_pkg::uop_t  op;
    exec_pkg::size_t sz;
    logic [31:0]     sel;
    logic [31:0]     a;
    logic [31:0]     b;
    cur_test = "alu";
    issue_alu(exec_pkg::OP_ADD, exec_pkg::SIZE_B, 32'h0000_0080, 32'h0000_0080);  // CF OF ZF
    issue_alu(exec_pkg::OP_AND, exec_pkg::SIZE_W, 32'h0000_f0f0, 32'h0000_0ff0);
    issue_alu(exec_pkg::OP_ADD, exec_pkg::SIZE_B, 32'h0000_00c0, 32'h0000_0080);
    issue_alu(exec_pkg::OP_NOT, exec_pkg::SIZE_D, 32'h1234_5678, 32'd0);          // Flags hold
    issue_alu(exec_pkg::OP_OR, exec_pkg::SIZE_D, 32'h8000_0000, 32'h0000_0001);
    for (int i = 0; i < N_ALU - 5; i++) begin
        sel = rand_bits(3) % 32'd6;
        case (sel)
            0:       op = exec_pkg::OP_ADD;
            1:       op = exec_pkg::OP_AND;
            2:       op = exec_pkg::OP_OR;
            3:       op = exec_pkg::OP_NOT;
            4:       op = exec_pkg::OP_SAL;
            default: op = exec_pkg::OP_SAR;
        endcase
        sz = size_from_index(rand_bits(2) % 32'd3);
        a  = rand_bits(32);
        b  = rand_bits(32);
        issue_alu(op, sz, a, b);
    end
    drain();
endtask

task automatic test_cmovc();
    logic [31:0] v;
    cur_test = "cmovc";
    for (int s = 0; s < 2; s++) begin
        if (s == 0)
            issue_alu(exec_pkg::OP_ADD, exec_pkg::SIZE_D, 32'hffff_ffff, 32'h0000_0002);
        else
            issue_alu(exec_pkg::OP_ADD, exec_pkg::SIZE_D, 32'h0000_1234, 32'h0000_0001);
        v = rand_bits(32);
        issue_alu(exec_pkg::OP_CMOVC, exec_pkg::SIZE_D, 32'd0, v);   // Right behind the ADD
    end
    drain();
endtask

function automatic exec_pkg::cond_t cc_from_index(input int i);
    case (i)
        0:       return exec_pkg::CC_ALWAYS;
        1:       return exec_pkg::CC_C;
        2:       return exec_pkg::CC_Z;
        default: return exec_pkg::CC_NZ;
    endcase
endfunction

task automatic test_branch();
    logic [31:0] pc;
    logic [31:0] disp;
    logic [31:0] target;
    cur_test = "branch";
    for (int s = 0; s < 2; s++) begin
        if (s == 0)
            issue_alu(exec_pkg::OP_ADD, exec_pkg::SIZE_D, 32'hffff_ffff, 32'h0000_0001);
        else
            issue_alu(exec_pkg::OP_ADD, exec_pkg::SIZE_D, 32'h0000_0001, 32'h0000_0001);
        // p[0] predicts direction, p[1] picks the right or a wrong target
        for (int c = 0; c < 5; c++) begin
            for (int p = 0; p < 4; p++) begin
                pc     = rand_bits(32);
                disp   = rand_bits(32);
                target = pc + disp;
                issue((c == 4) ? exec_pkg::OP_JMP : exec_pkg::OP_JCC,
                      (c == 4) ? exec_pkg::CC_NZ : cc_from_index(c), exec_pkg::SIZE_D,
                      32'd0, disp, pc, p[0], p[1] ? target : target + 32'd4,
                      32'h0000_8000, 32'h0000_0100, 32'h0000_0200);
            end
        end
    end
    drain();
endtask

task automatic issue_ptr(input exec_pkg::uop_t op, input int k, input logic [31:0] val);
    logic [31:0] sp;
    logic [31:0] si;
    logic [31:0] di;
    sp = rand_bits(32);
    si = rand_bits(32);
    di = rand_bits(32);
    issue(op, exec_pkg::CC_ALWAYS, size_from_index(k), val, val, 32'h0000_2000, 1'b0, 32'd0,
          sp, si, di);
endtask

task automatic test_pointers();
    logic [31:0] v;
    cur_test = "pointers";
    for (int k = 0; k < 3; k++) begin
        v = rand_bits(32);
        issue_ptr(exec_pkg::OP_PUSH, k, v);
        issue_ptr(exec_pkg::OP_POP, k, v);
    end
    issue_alu(exec_pkg::OP_STD, exec_pkg::SIZE_D, 32'd0, 32'd0);
    for (int k = 0; k < 3; k++)
        issue_ptr(exec_pkg::OP_MOVS, k, 32'd0);   // Walks down
    issue_alu(exec_pkg::OP_CLD, exec_pkg::SIZE_D, 32'd0, 32'd0);
    for (int k = 0; k < 3; k++)
        issue_ptr(exec_pkg::OP_MOVS, k, 32'd0);
    drain();
endtask

// ==== verif/exec_tb.sv ====
`timescale 1ns/1ps

module exec_tb;

    localparam int RESET_CYCLES = 8;
    localparam int N_ALU        = 65;
    localparam int N_CMOVC      = 4;
    localparam int N_BRANCH     = 42;
    localparam int N_PTR        = 14;
    localparam int TOTAL_OPS    = N_ALU + N_CMOVC + N_BRANCH + N_PTR;

    localparam exec_pkg::flags_t ARITH_FLAGS = exec_pkg::flags_t'((1 << exec_pkg::FLAG_CF) |
        (1 << exec_pkg::FLAG_ZF) | (1 << exec_pkg::FLAG_SF) | (1 << exec_pkg::FLAG_OF));
    localparam exec_pkg::flags_t DF_ONLY = exec_pkg::flags_t'(1 << exec_pkg::FLAG_DF);

    typedef struct packed {
        logic [31:0] due;          // Cycle count at the negedge that checks it
        logic        valid;
        logic        chk_result;
        logic [31:0] result;
        logic [4:0]  flags;
        logic        br_valid;
        logic        br_taken;
        logic        br_correct;
        logic [31:0] br_target;
        logic [31:0] esp;
        logic [31:0] esi;
        logic [31:0] edi;
    } exp_t;

    logic             clk;
    logic             rst_n;
    logic             valid_in;
    exec_pkg::uop_t   uop;
    exec_pkg::cond_t  cond;
    exec_pkg::size_t  size;
    exec_pkg::data_t  op1;
    exec_pkg::data_t  op2;
    exec_pkg::addr_t  eip;
    logic             pred_taken;
    exec_pkg::addr_t  pred_target;
    exec_pkg::data_t  esp_in;
    exec_pkg::data_t  esi_in;
    exec_pkg::data_t  edi_in;
    logic             out_valid;
    exec_pkg::data_t  result;
    exec_pkg::flags_t flags;
    logic             br_valid;
    logic             br_taken;
    logic             br_correct;
    exec_pkg::addr_t  br_target;
    exec_pkg::data_t  esp_out;
    exec_pkg::data_t  esi_out;
    exec_pkg::data_t  edi_out;

    exp_t             exp_q[$];    // Reference model output, oldest first
    exp_t             head;
    exec_pkg::flags_t model_flags;
    logic [31:0]      lfsr;
    logic [31:0]      cyc;
    string            cur_test;

    exec_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 32'd1;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;   // Taps 32 22 2 1
        else
            return s >> 1;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic exec_pkg::size_t size_from_index(input int i);
        case (i)
            0:       return exec_pkg::SIZE_B;
            1:       return exec_pkg::SIZE_W;
            default: return exec_pkg::SIZE_D;
        endcase
    endfunction

    task automatic check_val(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error: %s %s expected %h actual %h", cur_test, what, expected, actual);
            $display("Test FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // Result, candidate flags and written flags of one op
    function automatic void alu_model(input exec_pkg::uop_t op, input exec_pkg::size_t sz,
                                      input logic [31:0] a, input logic [31:0] b,
                                      input logic [31:0] pc, output logic [31:0] res,
                                      output exec_pkg::flags_t cand,
                                      output exec_pkg::flags_t wmask);
        int          n;
        int          amt;
        logic [31:0] mask;
        logic [31:0] am;
        logic [31:0] bm;
        logic [31:0] v;
        logic [32:0] wide;
        logic        cf;
        logic        of;
        n    = (sz == exec_pkg::SIZE_B) ? 8 : (sz == exec_pkg::SIZE_W) ? 16 : 32;
        mask = (n == 32) ? 32'hffff_ffff : (32'd1 << n) - 32'd1;
        am   = a & mask;
        bm   = b & mask;
        amt  = {27'd0, b[4:0]};
        v    = am;
        cf   = 1'b0;
        of   = 1'b0;
        case (op)
            exec_pkg::OP_ADD: begin
                wide = {1'b0, am} + {1'b0, bm};
                res  = wide[31:0] & mask;
                cf   = wide[n];
                of   = (am[n-1] == bm[n-1]) && (res[n-1] != am[n-1]);   // Same signs in, new sign out
            end
            exec_pkg::OP_AND: res = am & bm;
            exec_pkg::OP_OR:  res = am | bm;
            exec_pkg::OP_NOT: res = ~a & mask;
            exec_pkg::OP_SAL: begin
                for (int i = 0; i < amt; i++) begin
                    cf = v[n-1];
                    v  = (v << 1) & mask;
                end
                res = v;
                of  = v[n-1] ^ cf;
            end
            exec_pkg::OP_SAR: begin
                for (int i = 0; i < amt; i++) begin
                    cf = v[0];
                    v  = (v >> 1) | (am[n-1] ? 32'd1 << (n - 1) : 32'd0);   // Sign refill
                end
                res = v;
            end
            exec_pkg::OP_MOV, exec_pkg::OP_CMOVC: res = bm;
            exec_pkg::OP_JMP, exec_pkg::OP_JCC:   res = pc + b;
            exec_pkg::OP_PUSH: res = am;
            exec_pkg::OP_POP:  res = bm;
            default:           res = 32'd0;
        endcase
        cand                    = '0;
        cand[exec_pkg::FLAG_CF] = cf;
        cand[exec_pkg::FLAG_ZF] = (res == 32'd0);
        cand[exec_pkg::FLAG_SF] = res[n-1];
        cand[exec_pkg::FLAG_OF] = of;
        case (op)
            exec_pkg::OP_ADD, exec_pkg::OP_AND, exec_pkg::OP_OR,
            exec_pkg::OP_SAL, exec_pkg::OP_SAR: wmask = ARITH_FLAGS;
            exec_pkg::OP_CLD: wmask = DF_ONLY;
            exec_pkg::OP_STD: begin
                wmask                   = DF_ONLY;
                cand[exec_pkg::FLAG_DF] = 1'b1;
            end
            default: wmask = '0;
        endcase
    endfunction

    // Drives one op and queues what the DUT must show two edges later
    task automatic issue(input exec_pkg::uop_t op, input exec_pkg::cond_t cc,
                         input exec_pkg::size_t sz, input logic [31:0] a, input logic [31:0] b,
                         input logic [31:0] pc, input logic p_taken, input logic [31:0] p_target,
                         input logic [31:0] sp, input logic [31:0] si, input logic [31:0] di);
        exp_t             e;
        logic [31:0]      res;
        logic [31:0]      step;
        exec_pkg::flags_t cand;
        exec_pkg::flags_t wmask;
        exec_pkg::flags_t pre;
        logic             cond_ok;
        @(posedge clk);
        valid_in    <= 1'b1;
        uop         <= op;
        cond        <= cc;
        size        <= sz;
        op1         <= a;
        op2         <= b;
        eip         <= pc;
        pred_taken  <= p_taken;
        pred_target <= p_target;
        esp_in      <= sp;
        esi_in      <= si;
        edi_in      <= di;
        alu_model(op, sz, a, b, pc, res, cand, wmask);
        pre         = model_flags;   // Flags of all older ops
        model_flags = (pre & ~wmask) | (cand & wmask);
        case (cc)
            exec_pkg::CC_C:  cond_ok = pre[exec_pkg::FLAG_CF];
            exec_pkg::CC_Z:  cond_ok = pre[exec_pkg::FLAG_ZF];
            exec_pkg::CC_NZ: cond_ok = !pre[exec_pkg::FLAG_ZF];
            default:         cond_ok = 1'b1;
        endcase
        step         = (sz == exec_pkg::SIZE_B) ? 32'd1 : (sz == exec_pkg::SIZE_W) ? 32'd2 : 32'd4;
        e.due        = cyc + 32'd3;
        e.valid      = !(op == exec_pkg::OP_CMOVC && !pre[exec_pkg::FLAG_CF]);
        e.chk_result = !(op == exec_pkg::OP_MOVS || op == exec_pkg::OP_CLD ||
                         op == exec_pkg::OP_STD);
        e.result     = res;
        e.flags      = model_flags;
        e.br_valid   = (op == exec_pkg::OP_JMP) || (op == exec_pkg::OP_JCC);
        e.br_taken   = e.br_valid && ((op == exec_pkg::OP_JMP) || cond_ok);
        e.br_target  = e.br_taken ? res : pc + 32'd1;
        e.br_correct = e.br_valid && (e.br_taken == p_taken) && (!e.br_taken || p_target == res);
        e.esp        = sp;
        e.esi        = si;
        e.edi        = di;
        if (op == exec_pkg::OP_PUSH)
            e.esp = sp - step;
        else if (op == exec_pkg::OP_POP)
            e.esp = sp + step;
        else if (op == exec_pkg::OP_MOVS) begin
            e.esi = pre[exec_pkg::FLAG_DF] ? si - step : si + step;
            e.edi = pre[exec_pkg::FLAG_DF] ? di - step : di + step;
        end
        exp_q.push_back(e);
    endtask

    task automatic issue_alu(input exec_pkg::uop_t op, input exec_pkg::size_t sz,
                             input logic [31:0] a, input logic [31:0] b);
        issue(op, exec_pkg::CC_ALWAYS, sz, a, b, 32'h0000_1000, 1'b0, 32'd0,
              32'h0000_8000, 32'h0000_0100, 32'h0000_0200);
    endtask

    task automatic drain();
        @(posedge clk);
        valid_in <= 1'b0;
        while (exp_q.size() != 0)
            @(negedge clk);
        @(negedge clk);   // One idle cycle checked as well
    endtask

    // Outputs are compared mid-cycle, well away from the driving edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
                head = exp_q.pop_front();
                check_val("out_valid", 32'(head.valid), 32'(out_valid));
                if (head.valid && head.chk_result)
                    check_val("result", head.result, result);
                check_val("flags", 32'(head.flags), 32'(flags));
                check_val("br_valid", 32'(head.br_valid), 32'(br_valid));
                check_val("br_taken", 32'(head.br_taken), 32'(br_taken));
                check_val("br_correct", 32'(head.br_correct), 32'(br_correct));
                if (head.br_valid)
                    check_val("br_target", head.br_target, br_target);
                if (head.valid) begin
                    check_val("esp_out", head.esp, esp_out);
                    check_val("esi_out", head.esi, esi_out);
                    check_val("edi_out", head.edi, edi_out);
                end
            end else begin
                check_val("idle out_valid", 32'd0, 32'(out_valid));
                check_val("idle br_valid", 32'd0, 32'(br_valid));
            end
        end
    end

    `include "exec_tests.svh"

    initial begin
        repeat (TOTAL_OPS * 10 + RESET_CYCLES + 50) @(posedge clk);
        $display("watchdog expired before the tests finished");
        $display("Test FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        rst_n       = 1'b0;
        valid_in    = 1'b0;
        uop         = exec_pkg::OP_MOV;
        cond        = exec_pkg::CC_ALWAYS;
        size        = exec_pkg::SIZE_D;
        op1         = '0;
        op2         = '0;
        eip         = '0;
        pred_taken  = 1'b0;
        pred_target = '0;
        esp_in      = '0;
        esi_in      = '0;
        edi_in      = '0;
        lfsr        = 32'hf8da_7693;
        cyc         = '0;
        model_flags = '0;
        cur_test    = "reset";
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        test_reset();
        test_alu();
        test_cmovc();
        test_branch();
        test_pointers();
        $display("Test OK");
        $finish;
    end

endmodule
